// ==== design/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// first fetch after reset
`define RESET_PC 32'hbfc00000

`define DATA_W 32   // datapath and address width
`define REG_AW 5    // register number width

// jal destination
`define LINK_REG 5'd31

`endif

// ==== design/isa_pkg.sv ====
`include "cpu_defines.svh"

package isa_pkg;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;

    // r-type field layout, i-type and j-type reuse the low bits
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_t;

    //////////////////////////////
    // opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    //////////////////////////////
    // function field, special opcode only
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {IMM_SIGN, IMM_ZERO, IMM_UPPER} imm_kind_t;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_J, BR_JAL} br_kind_t;

    typedef struct packed {
        alu_op_t   alu_op;
        imm_kind_t imm_kind;
        logic      b_imm;      // operand b is the immediate
        logic      a_shamt;    // operand a is the shamt field
        logic      reg_write;
        reg_addr_t dest;
        logic      load;
        logic      store;
        br_kind_t  branch;
    } ctrl_t;

endpackage

// ==== design/pipe_pkg.sv ====
package pipe_pkg;
    import isa_pkg::*;

    // decode -> execute
    typedef struct packed {
        logic       valid;
        word_t      pc;
        ctrl_t      ctrl;
        reg_addr_t  rs;
        reg_addr_t  rt;
        word_t      rs_val;
        word_t      rt_val;
        word_t      imm;       // already extended
        logic [4:0] shamt;
        logic [25:0] jidx;
    } ex_payload_t;

    // execute -> memory, also reused as the writeback register
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     result;     // alu result, load/store address or link value
        word_t     store_data;
        reg_addr_t dest;
        logic      reg_write;
        logic      load;
        logic      store;
    } mem_payload_t;

    typedef struct packed {
        logic      we;
        reg_addr_t dest;
        word_t     value;
    } fwd_src_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } data_req_t;

    typedef struct packed {
        logic      we;
        word_t     pc;
        reg_addr_t num;
        word_t     data;
    } wb_trace_t;

endpackage

// ==== design/alu.sv ====
`include "cpu_defines.svh"

module alu import isa_pkg::*; (
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    input  alu_op_t           op,
    output logic [`DATA_W-1:0] y
);

    logic [4:0] sh;

    assign sh = a[4:0];   // shift amount

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_XOR:  y = a ^ b;
            ALU_NOR:  y = ~(a | b);
            ALU_SLT:  y = {{(`DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: y = {{(`DATA_W-1){1'b0}}, a < b};
            ALU_SLL:  y = b << sh;
            ALU_SRL:  y = b >> sh;
            ALU_SRA:  y = $signed(b) >>> sh;
            ALU_LUI:  y = {b[15:0], 16'h0};
            default:  y = '0;
        endcase
    end

endmodule

// ==== design/register_file.sv ====
`include "cpu_defines.svh"

module register_file (
    input  logic              clk,
    input  logic              resetn,
    input  logic [`REG_AW-1:0] ra0,
    input  logic [`REG_AW-1:0] ra1,
    output logic [`DATA_W-1:0] rd0,
    output logic [`DATA_W-1:0] rd1,
    input  logic              we,
    input  logic [`REG_AW-1:0] wa,
    input  logic [`DATA_W-1:0] wd
);

    logic [`DATA_W-1:0] regs [32];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // same-cycle write shows through
    assign rd0 = (ra0 == '0) ? '0 : (we && wa == ra0) ? wd : regs[ra0];
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];

endmodule

// ==== design/fetch_unit.sv ====
`include "cpu_defines.svh"

module fetch_unit import pipe_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic              stall,
    input  redirect_t         redirect,
    output logic [`DATA_W-1:0] imem_addr,
    output logic [`DATA_W-1:0] fetch_pc,     // address of the word now returning
    output logic              fetch_valid
);

    logic [`DATA_W-1:0] pc_q;       // next sequential fetch
    logic [`DATA_W-1:0] last_addr;  // address issued last cycle

    // a stall re-issues the same word so decode sees it again
    assign imem_addr = stall ? last_addr : pc_q;
    assign fetch_pc  = last_addr;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pc_q        <= `RESET_PC;
            last_addr   <= `RESET_PC;
            fetch_valid <= 1'b0;
        end else begin
            last_addr <= imem_addr;
            if (!stall) begin
                // word issued alongside a redirect is past the delay slot
                pc_q        <= redirect.taken ? redirect.target : pc_q + `DATA_W'(4);
                fetch_valid <= ~redirect.taken;
            end
        end
    end

endmodule

// ==== design/decode_stage.sv ====
`include "cpu_defines.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic [`DATA_W-1:0] imem_rdata,
    input  logic              fetch_valid,
    input  logic [`DATA_W-1:0] fetch_pc,
    input  logic              wb_we,
    input  logic [`REG_AW-1:0] wb_addr,
    input  logic [`DATA_W-1:0] wb_data,
    output logic              stall,
    output ex_payload_t       ex_out
);

    instr_t ins;
    ctrl_t  ctrl;
    logic   use_rs;
    logic   use_rt;
    word_t  rs_val;
    word_t  rt_val;
    word_t  imm_ext;

    assign ins = imem_rdata;

    register_file u_regs (
        .clk    (clk),
        .resetn (resetn),
        .ra0    (ins.rs),
        .ra1    (ins.rt),
        .rd0    (rs_val),
        .rd1    (rt_val),
        .we     (wb_we),
        .wa     (wb_addr),
        .wd     (wb_data)
    );

    //////////////////////////////
    // control decode
    always_comb begin
        ctrl   = '0;   // anything not matched below retires as a nop
        use_rs = 1'b0;
        use_rt = 1'b0;
        case (ins.opcode)
            OP_SPECIAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.dest      = ins.rd;
                case (ins.funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_NOR:  ctrl.alu_op = ALU_NOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    FN_SLL:  ctrl.alu_op = ALU_SLL;
                    FN_SRL:  ctrl.alu_op = ALU_SRL;
                    FN_SRA:  ctrl.alu_op = ALU_SRA;
                    default: ctrl.reg_write = 1'b0;
                endcase
                ctrl.a_shamt = ins.funct inside {FN_SLL, FN_SRL, FN_SRA};
                use_rs       = ctrl.reg_write & ~ctrl.a_shamt;
                use_rt       = ctrl.reg_write;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW: begin
                ctrl.b_imm     = 1'b1;
                ctrl.reg_write = (ins.opcode != OP_SW);
                ctrl.dest      = ins.rt;
                ctrl.load      = (ins.opcode == OP_LW);
                ctrl.store     = (ins.opcode == OP_SW);
                case (ins.opcode)
                    OP_SLTI:  ctrl.alu_op = ALU_SLT;
                    OP_SLTIU: ctrl.alu_op = ALU_SLTU;
                    OP_ANDI:  ctrl.alu_op = ALU_AND;
                    OP_ORI:   ctrl.alu_op = ALU_OR;
                    OP_XORI:  ctrl.alu_op = ALU_XOR;
                    OP_LUI:   ctrl.alu_op = ALU_LUI;
                    default:  ctrl.alu_op = ALU_ADD;   // addiu and address calc
                endcase
                ctrl.imm_kind = (ins.opcode inside {OP_ANDI, OP_ORI, OP_XORI}) ? IMM_ZERO :
                                (ins.opcode == OP_LUI) ? IMM_UPPER : IMM_SIGN;
                use_rs = (ins.opcode != OP_LUI);
                use_rt = ctrl.store;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.branch = (ins.opcode == OP_BEQ) ? BR_EQ : BR_NE;
                use_rs      = 1'b1;
                use_rt      = 1'b1;
            end
            OP_J: ctrl.branch = BR_J;
            OP_JAL: begin
                ctrl.branch    = BR_JAL;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = `LINK_REG;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (ctrl.imm_kind)
            IMM_SIGN: imm_ext = {{16{imem_rdata[15]}}, imem_rdata[15:0]};
            default:  imm_ext = {16'h0, imem_rdata[15:0]};   // lui shifts in the alu
        endcase
    end

    // load in execute feeding this word
    assign stall = fetch_valid & ex_out.valid & ex_out.ctrl.load
                 & (ex_out.ctrl.dest != '0)
                 & ((use_rs & (ex_out.ctrl.dest == ins.rs))
                  | (use_rt & (ex_out.ctrl.dest == ins.rt)));

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ex_out <= '0;
        end else begin
            ex_out.valid  <= fetch_valid & ~stall;   // bubble while stalled
            ex_out.pc     <= fetch_pc;
            ex_out.ctrl   <= ctrl;
            ex_out.rs     <= ins.rs;
            ex_out.rt     <= ins.rt;
            ex_out.rs_val <= rs_val;
            ex_out.rt_val <= rt_val;
            ex_out.imm    <= imm_ext;
            ex_out.shamt  <= ins.shamt;
            ex_out.jidx   <= imem_rdata[25:0];
        end
    end

endmodule

// ==== design/execute_stage.sv ====
`include "cpu_defines.svh"

module execute_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic         clk,
    input  logic         resetn,
    input  ex_payload_t  ex_in,
    input  fwd_src_t     wb_fwd,
    output redirect_t    redirect,
    output mem_payload_t mem_out
);

    fwd_src_t mem_fwd;
    word_t    rs_fwd;
    word_t    rt_fwd;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_y;
    word_t    pc_plus4;
    word_t    br_target;
    word_t    j_target;
    logic     take;

    // memory stage first, then writeback, then the value read in decode
    function automatic word_t pick_operand(reg_addr_t r, word_t rf_val,
                                           fwd_src_t m, fwd_src_t w);
        if (m.we && m.dest == r)
            return m.value;
        else if (w.we && w.dest == r)
            return w.value;
        else
            return rf_val;
    endfunction

    // a load's result is only an address here, its data comes via writeback
    assign mem_fwd.we    = mem_out.valid & mem_out.reg_write & ~mem_out.load
                         & (mem_out.dest != '0);
    assign mem_fwd.dest  = mem_out.dest;
    assign mem_fwd.value = mem_out.result;

    assign rs_fwd = pick_operand(ex_in.rs, ex_in.rs_val, mem_fwd, wb_fwd);
    assign rt_fwd = pick_operand(ex_in.rt, ex_in.rt_val, mem_fwd, wb_fwd);

    assign alu_a = ex_in.ctrl.a_shamt ? {{(`DATA_W-5){1'b0}}, ex_in.shamt} : rs_fwd;
    assign alu_b = ex_in.ctrl.b_imm ? ex_in.imm : rt_fwd;

    alu u_alu (
        .a  (alu_a),
        .b  (alu_b),
        .op (ex_in.ctrl.alu_op),
        .y  (alu_y)
    );

    //////////////////////////////
    // branch resolution
    assign pc_plus4  = ex_in.pc + `DATA_W'(4);
    assign br_target = pc_plus4 + {ex_in.imm[`DATA_W-3:0], 2'b00};
    assign j_target  = {pc_plus4[31:28], ex_in.jidx, 2'b00};   // region of the delay slot

    always_comb begin
        case (ex_in.ctrl.branch)
            BR_EQ:       take = (rs_fwd == rt_fwd);
            BR_NE:       take = (rs_fwd != rt_fwd);
            BR_J, BR_JAL: take = 1'b1;
            default:     take = 1'b0;
        endcase
    end

    assign redirect.taken  = ex_in.valid & take;
    assign redirect.target = (ex_in.ctrl.branch inside {BR_J, BR_JAL}) ? j_target : br_target;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            mem_out <= '0;
        end else begin
            mem_out.valid      <= ex_in.valid;
            mem_out.pc         <= ex_in.pc;
            mem_out.result     <= (ex_in.ctrl.branch == BR_JAL) ? pc_plus4 + `DATA_W'(4)
                                                                : alu_y;
            mem_out.store_data <= rt_fwd;
            mem_out.dest       <= ex_in.ctrl.dest;
            mem_out.reg_write  <= ex_in.ctrl.reg_write;
            mem_out.load       <= ex_in.ctrl.load;
            mem_out.store      <= ex_in.ctrl.store;
        end
    end

endmodule

// ==== design/memory_stage.sv ====
`include "cpu_defines.svh"

module memory_stage import pipe_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  mem_payload_t      mem_in,
    input  logic [`DATA_W-1:0] data_rdata,
    output data_req_t         data_req,
    output fwd_src_t          wb_fwd,
    output wb_trace_t         wb_trace
);

    mem_payload_t wb_q;   // writeback stage

    // address goes out every cycle, read word is back next cycle
    assign data_req.we    = mem_in.valid & mem_in.store;
    assign data_req.addr  = mem_in.result;
    assign data_req.wdata = mem_in.store_data;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wb_q <= '0;
        end else begin
            wb_q <= mem_in;
        end
    end

    assign wb_fwd.we    = wb_q.valid & wb_q.reg_write & (wb_q.dest != '0);   // r0 never written
    assign wb_fwd.dest  = wb_q.dest;
    assign wb_fwd.value = wb_q.load ? data_rdata : wb_q.result;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wb_trace <= '0;
        end else begin
            wb_trace.we   <= wb_fwd.we;
            wb_trace.pc   <= wb_q.pc;
            wb_trace.num  <= wb_fwd.dest;
            wb_trace.data <= wb_fwd.value;
        end
    end

endmodule

// ==== design/mips_core.sv ====
`include "cpu_defines.svh"

module mips_core import pipe_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    output logic [`DATA_W-1:0] imem_addr,
    input  logic [`DATA_W-1:0] imem_rdata,
    output data_req_t         data_req,
    input  logic [`DATA_W-1:0] data_rdata,
    output wb_trace_t         wb_trace
);

    logic               stall;
    logic               fetch_valid;
    logic [`DATA_W-1:0] fetch_pc;
    redirect_t          redirect;
    ex_payload_t        ex_payload;
    mem_payload_t       mem_payload;
    fwd_src_t           wb_fwd;

    fetch_unit u_fetch (
        .clk         (clk),
        .resetn      (resetn),
        .stall       (stall),
        .redirect    (redirect),
        .imem_addr   (imem_addr),
        .fetch_pc    (fetch_pc),
        .fetch_valid (fetch_valid)
    );

    decode_stage u_decode (
        .clk         (clk),
        .resetn      (resetn),
        .imem_rdata  (imem_rdata),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .wb_we       (wb_fwd.we),
        .wb_addr     (wb_fwd.dest),
        .wb_data     (wb_fwd.value),
        .stall       (stall),
        .ex_out      (ex_payload)
    );

    execute_stage u_execute (
        .clk      (clk),
        .resetn   (resetn),
        .ex_in    (ex_payload),
        .wb_fwd   (wb_fwd),
        .redirect (redirect),
        .mem_out  (mem_payload)
    );

    memory_stage u_memory (
        .clk        (clk),
        .resetn     (resetn),
        .mem_in     (mem_payload),
        .data_rdata (data_rdata),
        .data_req   (data_req),
        .wb_fwd     (wb_fwd),
        .wb_trace   (wb_trace)
    );

endmodule

// ==== bench/tb_checker.sv ====
`include "cpu_defines.svh"

module tb_checker import isa_pkg::*, pipe_pkg::*; #(
    parameter int N_WORDS    = 258,
    parameter int DMEM_DEPTH = 64
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        model_go,
    input  logic [31:0] prog  [N_WORDS],
    input  logic [31:0] dinit [DMEM_DEPTH],
    input  data_req_t   data_req,
    input  wb_trace_t   wb_trace,
    output bit          done,
    output int          mismatches,
    output int          other_errors,
    output int          wb_left,
    output int          st_left
);

    wb_trace_t exp_wb [$];   // expected register writes in program order
    data_req_t exp_st [$];   // expected stores
    wb_trace_t exp_w;
    data_req_t exp_s;
    bit        built;
    bit        seen_first;

    function automatic int slot_of(logic [31:0] addr);
        logic [31:0] d;
        d = addr - `RESET_PC;
        return int'(d >> 2);
    endfunction

    //////////////////////////////
    // reference model that runs the program once with delay slots
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] dm   [DMEM_DEPTH];
        logic [31:0] pc, npc, nnpc, ins, a, b, sx, zx, v, addr, end_pc;
        logic [4:0]  wd;
        bit          wr;
        int          steps;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < DMEM_DEPTH; i++)
            dm[i] = dinit[i];
        pc     = `RESET_PC;
        npc    = pc + 4;
        end_pc = `RESET_PC + 32'((N_WORDS - 2) * 4);
        steps  = 0;
        while (pc != end_pc && steps < 4 * N_WORDS && slot_of(pc) < N_WORDS) begin
            ins  = prog[slot_of(pc)];
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            sx   = {{16{ins[15]}}, ins[15:0]};
            zx   = {16'h0, ins[15:0]};
            nnpc = npc + 4;
            wr   = 1'b1;
            wd   = ins[20:16];
            v    = '0;
            case (ins[31:26])
                OP_SPECIAL: begin
                    wd = ins[15:11];
                    case (ins[5:0])
                        FN_ADDU: v = a + b;
                        FN_SUBU: v = a - b;
                        FN_AND:  v = a & b;
                        FN_OR:   v = a | b;
                        FN_XOR:  v = a ^ b;
                        FN_NOR:  v = ~(a | b);
                        FN_SLT:  v = {31'h0, $signed(a) < $signed(b)};
                        FN_SLTU: v = {31'h0, a < b};
                        FN_SLL:  v = b << ins[10:6];
                        FN_SRL:  v = b >> ins[10:6];
                        FN_SRA:  v = $signed(b) >>> ins[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: v = a + sx;
                OP_SLTI:  v = {31'h0, $signed(a) < $signed(sx)};
                OP_SLTIU: v = {31'h0, a < sx};
                OP_ANDI:  v = a & zx;
                OP_ORI:   v = a | zx;
                OP_XORI:  v = a ^ zx;
                OP_LUI:   v = {ins[15:0], 16'h0};
                OP_LW: begin
                    addr = a + sx;
                    v    = dm[addr[7:2]];
                end
                OP_SW: begin
                    wr   = 1'b0;
                    addr = a + sx;
                    dm[addr[7:2]] = b;
                    exp_st.push_back({1'b1, addr, b});
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (a == b)
                        nnpc = npc + (sx << 2);
                end
                OP_BNE: begin
                    wr = 1'b0;
                    if (a != b)
                        nnpc = npc + (sx << 2);
                end
                OP_J: begin
                    wr   = 1'b0;
                    nnpc = {npc[31:28], ins[25:0], 2'b00};
                end
                OP_JAL: begin
                    nnpc = {npc[31:28], ins[25:0], 2'b00};
                    wd   = 5'd31;
                    v    = pc + 8;   // past the delay slot
                end
                default: wr = 1'b0;   // unsupported opcode retires as a no-op
            endcase
            if (wr && wd != 5'd0) begin
                regs[wd] = v;
                exp_wb.push_back({1'b1, pc, wd, v});
            end
            pc    = npc;
            npc   = nnpc;
            steps = steps + 1;
        end
        if (pc != end_pc) begin
            other_errors++;
            $display("reference model never reached the end loop, stopped at pc %h", pc);
        end
    endtask

    //////////////////////////////
    // outputs are compared on the falling edge where they are stable
    always @(negedge clk) begin
        if (model_go && !built) begin
            run_model();
            built = 1'b1;
        end
        if (!resetn) begin
            if (wb_trace.we || data_req.we) begin
                other_errors++;
                $display("write strobe active during reset at time %0t", $time);
            end
        end else begin
            if (wb_trace.we) begin
                if (!seen_first && (wb_trace.pc < `RESET_PC ||
                                    wb_trace.pc >= `RESET_PC + 32'(N_WORDS * 4))) begin
                    mismatches++;
                    $display("mismatch at %0t: first retired pc %h lies outside the program",
                             $time, wb_trace.pc);
                end
                seen_first = 1'b1;
                if (exp_wb.size() == 0) begin
                    other_errors++;
                    $display("extra register write r%0d at time %0t", wb_trace.num, $time);
                end else begin
                    exp_w = exp_wb.pop_front();
                    if (exp_w != wb_trace) begin
                        mismatches++;
                        $display("mismatch at %0t: write pc %h r%0d = %h, expected pc %h r%0d = %h",
                                 $time, wb_trace.pc, wb_trace.num, wb_trace.data,
                                 exp_w.pc, exp_w.num, exp_w.data);
                    end
                end
            end
            if (data_req.we) begin
                if (exp_st.size() == 0) begin
                    other_errors++;
                    $display("extra store to %h at time %0t", data_req.addr, $time);
                end else begin
                    exp_s = exp_st.pop_front();
                    if (exp_s != data_req) begin
                        mismatches++;
                        $display("mismatch at %0t: store %h to %h, expected %h to %h",
                                 $time, data_req.wdata, data_req.addr, exp_s.wdata, exp_s.addr);
                    end
                end
            end
        end
        wb_left = exp_wb.size();
        st_left = exp_st.size();
        done    = built && wb_left == 0 && st_left == 0;
    end

endmodule

// ==== bench/tb_top.sv ====
`include "cpu_defines.svh"

module tb_top import isa_pkg::*, pipe_pkg::*; ();

    localparam int PROG_LEN        = 256;
    localparam int N_WORDS         = PROG_LEN + 2;   // program plus end loop and its slot
    localparam int IMEM_DEPTH      = 512;
    localparam int DMEM_DEPTH      = 64;
    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_CYCLES = PROG_LEN * 8 + RESET_CYCLES;

    localparam logic [5:0] R_FNS [11] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                                          FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
    localparam logic [5:0] I_OPS [7]  = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                                          OP_XORI, OP_LUI};

    logic               clk;
    logic               resetn;
    logic [`DATA_W-1:0] imem_addr;
    logic [`DATA_W-1:0] imem_rdata;
    data_req_t          data_req;
    logic [`DATA_W-1:0] data_rdata;
    wb_trace_t          wb_trace;

    logic [31:0] prog  [N_WORDS];
    logic [31:0] dinit [DMEM_DEPTH];
    logic [31:0] imem  [IMEM_DEPTH];
    logic [31:0] dmem  [DMEM_DEPTH];
    logic [31:0] iaddr_q;
    logic [31:0] daddr_q;
    logic        model_go;
    logic        done;
    int          mismatches;
    int          other_errors;
    int          wb_left;
    int          st_left;

    mips_core UUT (
        .clk        (clk),
        .resetn     (resetn),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .data_req   (data_req),
        .data_rdata (data_rdata),
        .wb_trace   (wb_trace)
    );

    tb_checker #(.N_WORDS(N_WORDS), .DMEM_DEPTH(DMEM_DEPTH)) u_checker (
        .clk          (clk),
        .resetn       (resetn),
        .model_go     (model_go),
        .prog         (prog),
        .dinit        (dinit),
        .data_req     (data_req),
        .wb_trace     (wb_trace),
        .done         (done),
        .mismatches   (mismatches),
        .other_errors (other_errors),
        .wb_left      (wb_left),
        .st_left      (st_left)
    );

    function automatic logic [31:0] r_type(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                           logic [4:0] rd, logic [4:0] sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_type(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                           logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // mostly r0..r7 so results get reused often and r31 now and then
    function automatic logic [4:0] pick_reg();
        int r;
        r = $urandom_range(0, 8);
        return (r == 8) ? 5'd31 : 5'(r);
    endfunction

    function automatic int imem_slot(logic [31:0] addr);
        logic [31:0] d;
        d = addr - `RESET_PC;
        return int'(d[10:2]);
    endfunction

    //////////////////////////////
    // random program
    task automatic build_program();
        int          k;
        int          tgt;
        bit          prev_br;
        logic [31:0] taddr;
        logic [15:0] off;
        logic [15:0] woff;
        prev_br = 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            k    = $urandom_range(0, 99);
            woff = {8'h0, 6'($urandom_range(0, DMEM_DEPTH - 1)), 2'b00};
            if (i <= PROG_LEN - 3 && !prev_br && k < 12) begin
                tgt   = $urandom_range(i + 2, PROG_LEN);   // forward only
                taddr = `RESET_PC + 32'(tgt * 4);
                off   = 16'(tgt - i - 1);
                case (k % 4)
                    0:       prog[i] = i_type(OP_BEQ, pick_reg(), pick_reg(), off);
                    1:       prog[i] = i_type(OP_BNE, pick_reg(), pick_reg(), off);
                    2:       prog[i] = {OP_J, taddr[27:2]};
                    default: prog[i] = {OP_JAL, taddr[27:2]};
                endcase
                prev_br = 1'b1;   // no branch in a delay slot
            end else begin
                prev_br = 1'b0;
                if (k < 30)
                    prog[i] = i_type(OP_LW, 5'd0, pick_reg(), woff);
                else if (k < 40)
                    prog[i] = i_type(OP_SW, 5'd0, pick_reg(), woff);
                else if (k < 72)
                    prog[i] = r_type(R_FNS[$urandom_range(0, 10)], pick_reg(), pick_reg(),
                                     pick_reg(), 5'($urandom_range(0, 31)));
                else
                    prog[i] = i_type(I_OPS[$urandom_range(0, 6)], pick_reg(), pick_reg(),
                                     16'($urandom()));
            end
        end
        taddr              = `RESET_PC + 32'(PROG_LEN * 4);
        prog[PROG_LEN]     = {OP_J, taddr[27:2]};   // jump to itself
        prog[PROG_LEN + 1] = 32'h0;
    endtask

    task automatic finish_run(input bit timed_out);
        $display("closing: %0d mismatches, %0d other errors, timeout %0d",
                 mismatches, other_errors, timed_out);
        if (!timed_out && mismatches == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    //////////////////////////////
    // sram models with one cycle read latency
    always @(posedge clk) begin
        iaddr_q <= imem_addr;
        daddr_q <= data_req.addr;
        if (resetn && data_req.we)
            dmem[data_req.addr[7:2]] <= data_req.wdata;
    end

    always @(negedge clk) begin
        imem_rdata <= imem[imem_slot(iaddr_q)];
        data_rdata <= dmem[daddr_q[7:2]];
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        void'($urandom(32'h9954));
        resetn     = 1'b0;
        model_go   = 1'b0;
        imem_rdata <= '0;
        data_rdata <= '0;
        build_program();
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dinit[i] = $urandom();
            dmem[i]  <= dinit[i];
        end
        // unused words hold an unsupported opcode tagged with their index
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = (i < N_WORDS) ? prog[i] : {6'h3f, 26'(i)};
        end
        model_go = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;
        wait (done);
        repeat (8) @(negedge clk);   // room for any extra write to show up
        finish_run(1'b0);
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * 4);
        $display("timeout: %0d register writes and %0d stores never seen", wb_left, st_left);
        finish_run(1'b1);
    end

endmodule

// ==== verilog.f ====
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/alu.sv
design/register_file.sv
design/fetch_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/mips_core.sv
bench/tb_checker.sv
bench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -f verilog.f --top-module tb_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
